// ==== logic/wiscPkg.sv ====
`default_nettype none

package wiscPkg;

    typedef logic [15:0] word_t;    // datapath word
    typedef logic [2:0]  regIdx_t;  // r0..r7, r0 is a normal reg

    // major opcode, instr[15:11]
    typedef enum logic [4:0] {
        OP_NOP   = 5'b00001,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_SLBI  = 5'b10010,
        OP_RFMT  = 5'b11011   // func in instr[1:0]
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,    // a + b
        ALU_RSUB,   // b - a
        ALU_XOR,    // a ^ b
        ALU_ANDN,   // a & ~b
        ALU_SLBI    // (a << 8) | b
    } aluOp_t;

    // operand source, same codes as forwardA/B
    typedef enum logic [1:0] {
        REGFILE    = 2'b00,
        FROM_MEMWB = 2'b01,
        FROM_EXMEM = 2'b10
    } fwdSel_t;

    typedef struct packed {
        logic   regWrite;   // writes rd
        logic   readsRs;    // uses rs as operand a
        logic   readsRt;    // uses rt as operand b
        logic   useImm;     // imm replaces operand b
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        logic    valid;
        ctrl_t   ctrl;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        word_t   rsData;    // regfile value at decode
        word_t   rtData;
        word_t   imm;       // already extended
    } idEx_t;

    typedef struct packed {
        logic    valid;
        logic    regWrite;  // qualified by valid
        regIdx_t rd;
        word_t   result;
    } exMem_t;

    typedef exMem_t memWb_t;  // mem stage is a plain copy

endpackage

`default_nettype wire

// ==== logic/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
    input  wiscPkg::word_t   instr,
    output wiscPkg::regIdx_t rs,
    output wiscPkg::regIdx_t rt,
    output wiscPkg::regIdx_t rd,
    output wiscPkg::word_t   imm,
    output wiscPkg::ctrl_t   ctrl
);

    import wiscPkg::*;

    opcode_t    opcode;
    logic [4:0] imm5;   // i-format immediate
    logic [7:0] imm8;   // slbi immediate
    logic [1:0] func;   // r-format op select

    assign opcode = opcode_t'(instr[15:11]);
    assign rs     = instr[10:8];  // same slot in every supported format
    assign rt     = instr[7:5];   // only meaningful when readsRt
    assign imm5   = instr[4:0];
    assign imm8   = instr[7:0];
    assign func   = instr[1:0];

    always_comb begin
        ctrl = '0;              // unknown opcode -> bubble
        rd   = instr[4:2];      // r-format rd slot
        imm  = '0;
        case (opcode)
            OP_RFMT: begin
                ctrl.regWrite = 1'b1;
                ctrl.readsRs  = 1'b1;
                ctrl.readsRt  = 1'b1;
                case (func)
                    2'b00:   ctrl.aluOp = ALU_ADD;
                    2'b01:   ctrl.aluOp = ALU_RSUB;  // rt - rs
                    2'b10:   ctrl.aluOp = ALU_XOR;
                    default: ctrl.aluOp = ALU_ANDN;  // rs & ~rt
                endcase
            end
            OP_ADDI, OP_SUBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.readsRs  = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = (opcode == OP_ADDI) ? ALU_ADD : ALU_RSUB;  // subi is imm - rs
                rd            = instr[7:5];
                imm           = {{11{imm5[4]}}, imm5};  // sign extend
            end
            OP_XORI, OP_ANDNI: begin
                ctrl.regWrite = 1'b1;
                ctrl.readsRs  = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = (opcode == OP_XORI) ? ALU_XOR : ALU_ANDN;
                rd            = instr[7:5];
                imm           = {11'd0, imm5};  // logic ops zero extend
            end
            OP_SLBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.readsRs  = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = ALU_SLBI;
                rd            = instr[10:8];  // rs is also the destination
                imm           = {8'd0, imm8};
            end
            OP_NOP:  ctrl = '0;  // no writeback
            default: ctrl = '0;  // unsupported, treated as nop
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  wiscPkg::regIdx_t rdAddrA,
    input  wiscPkg::regIdx_t rdAddrB,
    output wiscPkg::word_t   rdDataA,
    output wiscPkg::word_t   rdDataB,
    input  logic             wrEn,
    input  wiscPkg::regIdx_t wrAddr,
    input  wiscPkg::word_t   wrData
);

    import wiscPkg::*;

    word_t regs [8];  // r0..r7

    // same-cycle write wins over the stored value
    function automatic word_t readPort(input regIdx_t addr);
        word_t value;
        value = regs[addr];
        if (wrEn && (wrAddr == addr))
            value = wrData;  // write-through bypass
        return value;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;  // all regs start at zero
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = readPort(rdAddrA);
    assign rdDataB = readPort(rdAddrB);

endmodule

`default_nettype wire

// ==== logic/forwardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module forwardUnit (
    input  wiscPkg::regIdx_t idRs,
    input  wiscPkg::regIdx_t idRt,
    input  logic             readsRs,
    input  logic             readsRt,
    input  logic             exMemWrite,
    input  wiscPkg::regIdx_t exMemRd,
    input  logic             memWbWrite,
    input  wiscPkg::regIdx_t memWbRd,
    output wiscPkg::fwdSel_t fwdA,
    output wiscPkg::fwdSel_t fwdB
);

    import wiscPkg::*;

    logic exHitA;   // ex->ex match on rs
    logic exHitB;   // ex->ex match on rt
    logic memHitA;  // mem->ex match on rs
    logic memHitB;  // mem->ex match on rt

    // r0 stays in the compare, it holds data in this ISA
    assign exHitA  = exMemWrite && readsRs && (exMemRd == idRs);
    assign exHitB  = exMemWrite && readsRt && (exMemRd == idRt);  // imm forms never hit
    assign memHitA = memWbWrite && readsRs && (memWbRd == idRs);
    assign memHitB = memWbWrite && readsRt && (memWbRd == idRt);

    // youngest producer first
    function automatic fwdSel_t pickSource(input logic exHit, input logic memHit);
        fwdSel_t sel;
        sel = REGFILE;
        if (exHit)
            sel = FROM_EXMEM;
        else if (memHit)
            sel = FROM_MEMWB;  // only when ex/mem does not match
        return sel;
    endfunction

    assign fwdA = pickSource(exHitA, memHitA);
    assign fwdB = pickSource(exHitB, memHitB);

endmodule

`default_nettype wire

// ==== logic/aluCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluCore (
    input  wiscPkg::aluOp_t aluOp,
    input  wiscPkg::word_t  opA,
    input  wiscPkg::word_t  opB,
    output wiscPkg::word_t  result
);

    import wiscPkg::*;

    word_t sum;      // a + b
    word_t revDiff;  // b - a
    word_t andNot;   // a & ~b
    word_t slbiVal;  // a shifted up a byte, imm8 below

    assign sum     = opA + opB;
    assign revDiff = opB - opA;   // sub and subi both take rs as a
    assign andNot  = opA & ~opB;
    assign slbiVal = {opA[7:0], 8'h00} | opB;

    always_comb begin
        case (aluOp)
            ALU_ADD:  result = sum;
            ALU_RSUB: result = revDiff;
            ALU_XOR:  result = opA ^ opB;
            ALU_ANDN: result = andNot;
            ALU_SLBI: result = slbiVal;
            default:  result = '0;  // unused encodings
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/execPipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module execPipe (
    input  logic             clk,
    input  logic             rstN,
    input  wiscPkg::word_t   instr,
    input  logic             instrValid,
    output logic             wbValid,
    output wiscPkg::regIdx_t wbReg,
    output wiscPkg::word_t   wbData
);

    import wiscPkg::*;

    regIdx_t decRs;
    regIdx_t decRt;
    regIdx_t decRd;
    word_t   decImm;
    ctrl_t   decCtrl;
    word_t   rfDataA;    // regfile read, id cycle
    word_t   rfDataB;
    idEx_t   idEx;
    exMem_t  exMem;
    memWb_t  memWb;
    fwdSel_t fwdA;
    fwdSel_t fwdB;
    word_t   opA;
    word_t   opBFwd;     // b before the imm mux
    word_t   opB;
    word_t   aluResult;
    logic    wbEn;       // valid writer in mem/wb

    instrDecode i_decode (
        .instr (instr),
        .rs    (decRs),
        .rt    (decRt),
        .rd    (decRd),
        .imm   (decImm),
        .ctrl  (decCtrl)
    );

    regFile i_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (decRs),
        .rdAddrB (decRt),
        .rdDataA (rfDataA),
        .rdDataB (rfDataB),
        .wrEn    (wbEn),
        .wrAddr  (memWb.rd),
        .wrData  (memWb.result)
    );

    forwardUnit i_forward (
        .idRs       (idEx.rs),
        .idRt       (idEx.rt),
        .readsRs    (idEx.ctrl.readsRs),
        .readsRt    (idEx.ctrl.readsRt),
        .exMemWrite (exMem.regWrite),
        .exMemRd    (exMem.rd),
        .memWbWrite (memWb.regWrite),
        .memWbRd    (memWb.rd),
        .fwdA       (fwdA),
        .fwdB       (fwdB)
    );

    function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal);
        word_t value;
        case (sel)
            FROM_EXMEM: value = exMem.result;  // distance 1
            FROM_MEMWB: value = memWb.result;  // distance 2
            default:    value = regVal;        // regfile, incl. bypass
        endcase
        return value;
    endfunction

    assign opA    = fwdMux(fwdA, idEx.rsData);
    assign opBFwd = fwdMux(fwdB, idEx.rtData);
    assign opB    = idEx.ctrl.useImm ? idEx.imm : opBFwd;

    aluCore i_alu (
        .aluOp  (idEx.ctrl.aluOp),
        .opA    (opA),
        .opB    (opB),
        .result (aluResult)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx  <= '0;
            exMem <= '0;
            memWb <= '0;
        end else begin
            idEx.valid     <= instrValid;     // low inserts a bubble
            idEx.ctrl      <= decCtrl;
            idEx.rs        <= decRs;
            idEx.rt        <= decRt;
            idEx.rd        <= decRd;
            idEx.rsData    <= rfDataA;
            idEx.rtData    <= rfDataB;
            idEx.imm       <= decImm;
            exMem.valid    <= idEx.valid;
            exMem.regWrite <= idEx.valid & idEx.ctrl.regWrite;  // bubbles never write
            exMem.rd       <= idEx.rd;
            exMem.result   <= aluResult;
            memWb          <= exMem;          // no memory access here
        end
    end

    assign wbEn    = memWb.valid & memWb.regWrite;
    assign wbValid = wbEn;
    assign wbReg   = memWb.rd;
    assign wbData  = memWb.result;

endmodule

`default_nettype wire

// ==== bench/execPipeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module execPipeTb;

    import wiscPkg::*;

    localparam int NUM_TESTS     = 5;
    localparam int ISSUE_SLOTS   = 460;  // instrs plus worst-case bubbles, all tests
    localparam int TIMEOUT_LIMIT = 5 + ISSUE_SLOTS + 3 * NUM_TESTS + 50;  // reset + drain + margin

    logic    clk;
    logic    rstN;
    word_t   instr;
    logic    instrValid;
    logic    wbValid;
    regIdx_t wbReg;
    word_t   wbData;

    word_t   refRegs [8];     // architectural state, program order
    regIdx_t expReg [$];      // pending writebacks
    word_t   expData [$];
    int      expCycle [$];    // issue cycle of each pending writeback
    int      cycleCount = 0;
    int      checkCount = 0;
    int      errorCount = 0;
    int      testErrors = 0;  // errors before the current test
    integer  seed = 32'h25940b0d;

    execPipe i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    always #2 clk = ~clk;  // 4 ns period

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TIMEOUT_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // outputs are settled mid-cycle
    always @(negedge clk) begin
        if (rstN && wbValid) begin
            if (expData.size() == 0) begin
                errorCount++;
                $display("writeback to r%0d at %0t ns with none expected", wbReg, $time);
            end else begin
                checkEq("wbReg", 32'(expReg.pop_front()), 32'(wbReg));
                checkEq("wbData", 32'(expData.pop_front()), 32'(wbData));
                checkEq("latency", 32'(expCycle.pop_front() + 3), 32'(cycleCount));
            end
        end
    end

    function automatic word_t encR(input regIdx_t rs, input regIdx_t rt, input regIdx_t rd,
                                   input logic [1:0] func);
        return {OP_RFMT, rs, rt, rd, func};
    endfunction

    function automatic word_t encI(input logic [4:0] op, input regIdx_t rs, input regIdx_t rd,
                                   input logic [4:0] imm5);
        return {op, rs, rd, imm5};
    endfunction

    function automatic word_t encSlbi(input regIdx_t rs, input logic [7:0] imm8);
        return {OP_SLBI, rs, imm8};
    endfunction

    // ISA rules applied one instruction at a time
    task automatic modelInstr(input word_t w);
        word_t   a;
        word_t   b;
        word_t   sext;
        word_t   zext;
        word_t   res;
        regIdx_t dest;
        logic    writes;
        a      = refRegs[w[10:8]];
        b      = refRegs[w[7:5]];
        sext   = {{11{w[4]}}, w[4:0]};
        zext   = {11'd0, w[4:0]};
        dest   = w[7:5];  // i-format rd
        writes = 1'b1;
        res    = '0;
        case (w[15:11])
            5'b11011: begin
                dest = w[4:2];
                case (w[1:0])
                    2'b00:   res = a + b;
                    2'b01:   res = b - a;   // rt minus rs
                    2'b10:   res = a ^ b;
                    default: res = a & ~b;
                endcase
            end
            5'b01000: res = a + sext;
            5'b01001: res = sext - a;      // imm minus rs
            5'b01010: res = a ^ zext;
            5'b01011: res = a & ~zext;
            5'b10010: begin
                dest = w[10:8];            // slbi writes rs
                res  = (a << 8) | {8'd0, w[7:0]};
            end
            default: writes = 1'b0;        // nop and unsupported
        endcase
        if (writes) begin
            refRegs[dest] = res;
            expReg.push_back(dest);
            expData.push_back(res);
            expCycle.push_back(cycleCount);
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue(input word_t w);
        instr      = w;
        instrValid = 1'b1;
        modelInstr(w);
        stepCycle();
    endtask

    task automatic bubble();
        instr      = 16'($random(seed));  // junk word, must be ignored
        instrValid = 1'b0;
        stepCycle();
    endtask

    task automatic endTest(input string name);
        instrValid = 1'b0;
        while (expData.size() != 0)
            stepCycle();  // let the pipe drain
        $display("%-14s done, %0d errors", name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    task automatic resetWriteTest();
        checkEq("wbValid", 32'(1'b0), 32'(wbValid));  // idle out of reset
        for (int i = 0; i < 8; i++)
            issue(encI(OP_ADDI, regIdx_t'(i), regIdx_t'(i), 5'(i * 5 - 9)));  // rs still zero
        endTest("reset/addi");
    endtask

    task automatic exMemFwdTest();
        issue(encI(OP_ADDI, 3'd1, 3'd1, 5'd7));
        issue(encR(3'd1, 3'd1, 3'd2, 2'b00));  // prev on rs and rt
        issue(encR(3'd2, 3'd3, 3'd4, 2'b10));  // prev on rs
        issue(encR(3'd6, 3'd4, 3'd5, 2'b11));  // prev on rt
        issue(encR(3'd0, 3'd5, 3'd6, 2'b01));
        issue(encSlbi(3'd6, 8'hA5));           // slbi reads prev
        issue(encSlbi(3'd6, 8'h3C));
        issue(encR(3'd6, 3'd6, 3'd7, 2'b00));
        endTest("ex/mem fwd");
    endtask

    task automatic distanceTest();
        issue(encI(OP_ADDI, 3'd0, 3'd1, 5'h0b));
        bubble();
        issue(encR(3'd1, 3'd1, 3'd2, 2'b00));   // distance 2, mem/wb
        issue(encI(OP_XORI, 3'd3, 3'd3, 5'h15));
        issue(encI(OP_ANDNI, 3'd4, 3'd4, 5'h01));
        issue(encR(3'd3, 3'd2, 3'd5, 2'b01));   // r3 at 2, r2 at 3
        bubble();
        bubble();
        issue(encR(3'd5, 3'd5, 3'd6, 2'b00));   // distance 3, regfile bypass
        bubble();
        bubble();
        bubble();
        issue(encSlbi(3'd6, 8'h81));            // stored value
        endTest("distance 2/3");
    endtask

    task automatic priorityTest();
        issue(encI(OP_XORI, 3'd0, 3'd2, 5'h07));  // older r2
        issue(encI(OP_ADDI, 3'd0, 3'd2, 5'h09));  // younger r2
        issue(encR(3'd2, 3'd2, 3'd3, 2'b00));
        issue(encI(OP_ADDI, 3'd1, 3'd7, 5'h1f));
        issue(encI(OP_SUBI, 3'd1, 3'd7, 5'h04));
        bubble();
        issue(encR(3'd0, 3'd7, 3'd4, 2'b11));     // mem/wb beats bypassed older
        issue(encI(OP_ADDI, 3'd5, 3'd4, 5'h03));  // rt field hits ex/mem rd
        issue(encSlbi(3'd1, 8'h80));              // imm8[7:5] hits r4
        endTest("priority");
    endtask

    task automatic randomTest();
        int      kind;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        for (int n = 0; n < 200; n++) begin
            kind = $unsigned($random(seed)) % 10;
            rs   = regIdx_t'($random(seed));
            rt   = regIdx_t'($random(seed));
            rd   = regIdx_t'($random(seed));
            case (kind)
                0, 1, 2, 3: issue(encR(rs, rt, rd, 2'($random(seed))));
                4:       issue(encI(OP_ADDI, rs, rd, 5'($random(seed))));
                5:       issue(encI(OP_SUBI, rs, rd, 5'($random(seed))));
                6:       issue(encI(OP_XORI, rs, rd, 5'($random(seed))));
                7:       issue(encI(OP_ANDNI, rs, rd, 5'($random(seed))));
                8:       issue(encSlbi(rs, 8'($random(seed))));
                default: issue({OP_NOP, 11'($random(seed))});  // no writeback
            endcase
            if (($random(seed) & 3) == 0)
                bubble();
        end
        endTest("random");
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        for (int i = 0; i < 8; i++)
            refRegs[i] = '0;  // matches regfile reset
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        resetWriteTest();
        exMemFwdTest();
        distanceTest();
        priorityTest();
        randomTest();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/wiscPkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/forwardUnit.sv
logic/aluCore.sv
logic/execPipe.sv
bench/execPipeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execPipe testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module execPipeTb -o execPipeSim
./obj_dir/execPipeSim > "$LOG"
cat "$LOG"

if grep -q "\*\* FAIL \*\*" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
